//--- duc_chain.f
+incdir+include
hdl/duc_pkg.sv
hdl/duc_settings.sv
hdl/duc_interp.sv
hdl/duc_nco.sv
hdl/duc_mixer.sv
hdl/duc_top.sv
dv/duc_sva.sv
dv/duc_tb.sv

//--- Makefile
# Verilator build and run of the up-converter testbench

VERILATOR ?= verilator
TOP       ?= duc_tb
FILELIST  ?= duc_chain.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

FAIL_MSG  := \*\*\* TEST FAILED \*\*\*
PASS_MSG  := \*\*\* TEST PASSED \*\*\*

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/duc_tb.sv
// Directed testbench for duc_top, run through the file list with the Makefile sim target
`timescale 1ns/10ps

module duc_tb;

  import duc_pkg::*;

  `include "duc_sine_table.svh"

  localparam logic [31:0] SEED    = 32'd43603;
  localparam int          RST_CYC = 16;
  // Register writes, drain and settle for one test
  localparam int          SETUP_CYC = 40;
  // Items times repeats per test, back-pressure counted four times over
  localparam int          ITEM_CYC  = 8 + (6 * 4 + 5) + (10 * 2 + 6 * 2) + 6 + 4 * (12 * 3);
  localparam int          LIMIT_CYC = 2 * (RST_CYC + 6 * SETUP_CYC + ITEM_CYC);

  logic              ce_clk;
  logic              i_rst;
  logic              i_set_stb;
  logic [7:0]        i_set_addr;
  logic [31:0]       i_set_data;
  logic [7:0]        i_rb_addr;
  logic [31:0]       o_rb_data;
  logic              i_in_valid;
  logic              o_in_ready;
  logic [ITEM_W-1:0] i_in_data;
  logic              i_in_last;
  logic              o_out_valid;
  logic              i_out_ready;
  logic [ITEM_W-1:0] o_out_data;
  logic              o_out_last;

  logic [31:0]       rng;
  logic [31:0]       bp_state;
  logic              bp_on;
  int                errors;
  int                checks;
  int                cycles;
  // Clock edges from driving an item to its transfer
  int                acc_wait;

  // Reference model state, mirrors the register contents
  logic [15:0]       m_phase;
  logic [15:0]       m_freq;
  longint            m_scale;
  int                m_rate;

  logic [ITEM_W-1:0] exp_data[$];
  logic              exp_last[$];
  logic [ITEM_W-1:0] got_data[$];
  logic              got_last[$];

  duc_top UUT (.*);

  initial begin
    ce_clk = 1'b0;
    forever #5 ce_clk = ~ce_clk;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [15:0] clip16(input longint v);
    if (v > 32767) begin
      return 16'h7FFF;
    end else if (v < -32768) begin
      return 16'h8000;
    end
    return v[15:0];
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    @(negedge ce_clk);
    i_set_stb  = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
    @(negedge ce_clk);
    i_set_stb  = 1'b0;
  endtask

  // Readback is registered, one edge between address and data
  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
    @(negedge ce_clk);
    i_rb_addr = addr;
    @(negedge ce_clk);
    data = o_rb_data;
  endtask

  task automatic configure(input logic [15:0] freq, input logic [15:0] scale, input int rate);
    write_reg(SR_FREQ, 32'(freq));
    write_reg(SR_SCALE, 32'(scale));
    write_reg(SR_INTERP, 32'(rate));
    write_reg(SR_CLEAR, 32'd0);
    m_freq  = freq;
    m_scale = longint'(scale);
    m_rate  = (rate < 1) ? 1 : (rate > INTERP_MAX) ? INTERP_MAX : rate;
    m_phase = '0;
  endtask

  // Model, R outputs per item, phase steps once per output
  task automatic expect_item(input logic [ITEM_W-1:0] item, input logic last);
    longint xi;
    longint xq;
    longint sn;
    longint cs;
    longint mi;
    longint mq;
    int     idx;
    int     k;
    xi = longint'($signed(item[15:0]));
    xq = longint'($signed(item[31:16]));
    for (k = 0; k < m_rate; k++) begin
      idx = int'(m_phase[15:10]);
      sn  = longint'(SINE_TABLE[idx]);
      cs  = longint'(SINE_TABLE[(idx + 16) % 64]);
      mi  = ((xi * cs) - (xq * sn)) >>> 15;
      mq  = ((xi * sn) + (xq * cs)) >>> 15;
      mi  = (mi * m_scale) >>> 14;
      mq  = (mq * m_scale) >>> 14;
      exp_data.push_back({clip16(mq), clip16(mi)});
      exp_last.push_back(last && (k == m_rate - 1));
      m_phase = m_phase + m_freq;
    end
  endtask

  task automatic send_item(input logic [ITEM_W-1:0] item, input logic last);
    @(negedge ce_clk);
    i_in_valid = 1'b1;
    i_in_data  = item;
    i_in_last  = last;
    expect_item(item, last);
    acc_wait = 1;
    @(posedge ce_clk);
    while (!o_in_ready) begin
      @(posedge ce_clk);
      acc_wait++;
    end
  endtask

  task automatic end_stream();
    @(negedge ce_clk);
    i_in_valid = 1'b0;
    i_in_last  = 1'b0;
  endtask

  // Without stalls the first item goes in at once, later ones every R cycles
  task automatic send_random(input int count, input int last_at);
    int k;
    for (k = 0; k < count; k++) begin
      rng = xorshift(rng);
      send_item(rng, (k == last_at) || (k == count - 1));
      if (!bp_on) begin
        check_eq("in_gap", 32'(acc_wait), (k == 0) ? 32'd1 : 32'(m_rate));
      end
    end
    end_stream();
  endtask

  task automatic report(input string name, input int err0);
    $display("%-16s %s", name, (errors == err0) ? "ok" : "failed");
  endtask

  // Wait for every expected output, then compare in order
  task automatic finish_test(input string name, input int err0);
    int n;
    int k;
    while (got_data.size() < exp_data.size()) begin
      @(posedge ce_clk);
    end
    repeat (8) @(posedge ce_clk);
    check_eq("out_count", 32'(got_data.size()), 32'(exp_data.size()));
    n = (got_data.size() < exp_data.size()) ? got_data.size() : exp_data.size();
    for (k = 0; k < n; k++) begin
      check_eq("o_out_data", got_data[k], exp_data[k]);
      check_eq("o_out_last", 32'(got_last[k]), 32'(exp_last[k]));
    end
    got_data.delete();
    got_last.delete();
    exp_data.delete();
    exp_last.delete();
    report(name, err0);
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------

  task automatic test_readback();
    int          err0;
    logic [31:0] data;
    err0 = errors;
    write_reg(SR_FREQ, 32'h0000_1234);
    read_reg(RB_COMPAT, data);
    check_eq("rb_compat", data, 32'h0000_0001);
    read_reg(RB_INTERP_MAX, data);
    check_eq("rb_interp_max", data, 32'd16);
    read_reg(8'h55, data);
    check_eq("rb_unknown", data, 32'h0BAD_C0DE);
    read_reg(RB_FREQ, data);
    check_eq("rb_freq", data, 32'h0000_1234);
    report("readback", err0);
  endtask

  task automatic test_passthrough();
    int err0;
    err0 = errors;
    configure(16'h0000, 16'd16384, 1);
    send_random(8, -1);
    finish_test("passthrough", err0);
  endtask

  task automatic test_interp();
    int err0;
    err0 = errors;
    configure(16'h0000, 16'd16384, 4);
    send_random(6, 2);
    finish_test("interp_r4", err0);
    err0 = errors;
    // Zero is stored as a factor of one
    configure(16'h0000, 16'd16384, 0);
    send_random(5, 1);
    finish_test("interp_r0", err0);
  endtask

  task automatic test_mixing();
    int err0;
    err0 = errors;
    configure(16'h0400, 16'd12000, 2);
    send_random(10, 4);
    finish_test("mixing", err0);
    err0 = errors;
    write_reg(SR_CLEAR, 32'd0);
    m_phase = '0;
    send_random(6, -1);
    finish_test("mixing_clear", err0);
  endtask

  task automatic test_saturation();
    int err0;
    err0 = errors;
    configure(16'h2000, 16'h7FFF, 1);
    send_item({16'h8000, 16'h7FFF}, 1'b0);
    send_item({16'h7FFF, 16'h8000}, 1'b0);
    send_item({16'h7FFF, 16'h7FFF}, 1'b0);
    send_item({16'h8000, 16'h8000}, 1'b0);
    send_item({16'h7FFF, 16'h0000}, 1'b0);
    send_item({16'h03E8, 16'hFC18}, 1'b1);
    end_stream();
    finish_test("saturation", err0);
  endtask

  task automatic test_backpressure();
    int err0;
    err0 = errors;
    configure(16'h0300, 16'd16384, 3);
    bp_on = 1'b1;
    send_random(12, 4);
    finish_test("backpressure", err0);
    bp_on = 1'b0;
  endtask

  // ----------------------------------------
  // Output monitor, back-pressure and timeout
  // ----------------------------------------

  always @(posedge ce_clk) begin
    if (o_out_valid && i_out_ready) begin
      got_data.push_back(o_out_data);
      got_last.push_back(o_out_last);
    end
  end

  always @(negedge ce_clk) begin
    if (bp_on) begin
      bp_state    = xorshift(bp_state);
      i_out_ready = bp_state[7];
    end else begin
      i_out_ready = 1'b1;
    end
  end

  always @(posedge ce_clk) begin
    cycles++;
    if (cycles >= LIMIT_CYC) begin
      $display("Timeout: run did not finish within %0d cycles", LIMIT_CYC);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    i_rst       = 1'b1;
    i_set_stb   = 1'b0;
    i_set_addr  = '0;
    i_set_data  = '0;
    i_rb_addr   = '0;
    i_in_valid  = 1'b0;
    i_in_data   = '0;
    i_in_last   = 1'b0;
    i_out_ready = 1'b1;
    bp_on       = 1'b0;
    rng         = SEED;
    bp_state    = xorshift(SEED);
    errors      = 0;
    checks      = 0;
    cycles      = 0;
    acc_wait    = 0;
    repeat (RST_CYC) @(posedge ce_clk);
    @(negedge ce_clk);
    i_rst = 1'b0;

    test_readback();
    test_passthrough();
    test_interp();
    test_mixing();
    test_saturation();
    test_backpressure();

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- dv/duc_sva.sv
// Stream handshake and latency assertions, attached to duc_top by the bind at the end
`timescale 1ns/10ps

module duc_sva (
  input logic                       ce_clk,
  input logic                       i_rst,
  input logic                       i_in_valid,
  input logic                       o_in_ready,
  input logic [duc_pkg::ITEM_W-1:0] i_in_data,
  input logic                       i_in_last,
  input logic                       o_out_valid,
  input logic                       i_out_ready,
  input logic [duc_pkg::ITEM_W-1:0] o_out_data,
  input logic                       o_out_last
);

  // ----------------------------------------
  // Input stream, held by the source
  // ----------------------------------------
  a_in_hold: assert property (@(posedge ce_clk) disable iff (i_rst)
    i_in_valid && !o_in_ready |=> i_in_valid && $stable(i_in_data) && $stable(i_in_last))
    else $error("input stream dropped valid or changed data while stalled");

  // ----------------------------------------
  // Output stream, held by the mixer
  // ----------------------------------------
  a_out_hold: assert property (@(posedge ce_clk) disable iff (i_rst)
    o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_out_data) && $stable(o_out_last))
    else $error("output stream dropped valid or changed data while stalled");

  // Ready to take input right after reset
  a_rst_ready: assert property (@(posedge ce_clk)
    $fell(i_rst) |-> o_in_ready)
    else $error("o_in_ready low after reset");

  // Three cycle latency when the output is never stalled
  a_latency: assert property (@(posedge ce_clk) disable iff (i_rst)
    (i_in_valid && o_in_ready && i_out_ready) ##1 i_out_ready ##1 i_out_ready |=> o_out_valid)
    else $error("no output three cycles after an input transfer");

endmodule

bind duc_top duc_sva duc_sva_i (.*);

//--- hdl/duc_top.sv
// Top of the up-converter chain, joins settings, interpolator, NCO and mixer on ce_clk
`timescale 1ns/10ps
`default_nettype none

module duc_top (
  input  logic                       ce_clk,
  input  logic                       i_rst,

  // Settings bus
  input  logic                       i_set_stb,
  input  logic [7:0]                 i_set_addr,
  input  logic [31:0]                i_set_data,
  input  logic [7:0]                 i_rb_addr,
  output logic [31:0]                o_rb_data,

  // Baseband input stream
  input  logic                       i_in_valid,
  output logic                       o_in_ready,
  input  logic [duc_pkg::ITEM_W-1:0] i_in_data,
  input  logic                       i_in_last,

  // Up-converted output stream
  output logic                       o_out_valid,
  input  logic                       i_out_ready,
  output logic [duc_pkg::ITEM_W-1:0] o_out_data,
  output logic                       o_out_last
);

  import duc_pkg::*;

  logic [PHASE_W-1:0]         freq;
  logic [SCALE_W-1:0]         scale;
  logic [4:0]                 interp;
  logic                       clear;
  logic                       interp_valid;
  logic                       mix_ready;
  logic [ITEM_W-1:0]          interp_data;
  logic                       interp_last;
  logic signed [SAMPLE_W-1:0] nco_cos;
  logic signed [SAMPLE_W-1:0] nco_sin;
  logic                       nco_step;

  duc_settings duc_settings_i (
    .ce_clk     (ce_clk),
    .i_rst      (i_rst),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .i_rb_addr  (i_rb_addr),
    .o_rb_data  (o_rb_data),
    .o_freq     (freq),
    .o_scale    (scale),
    .o_interp   (interp),
    .o_clear    (clear)
  );

  duc_interp duc_interp_i (
    .ce_clk      (ce_clk),
    .i_rst       (i_rst),
    .i_clear     (clear),
    .i_interp    (interp),
    .i_in_valid  (i_in_valid),
    .o_in_ready  (o_in_ready),
    .i_in_data   (i_in_data),
    .i_in_last   (i_in_last),
    .o_out_valid (interp_valid),
    .i_out_ready (mix_ready),
    .o_out_data  (interp_data),
    .o_out_last  (interp_last)
  );

  // Steps only when the mixer takes a sample
  duc_nco duc_nco_i (
    .ce_clk  (ce_clk),
    .i_rst   (i_rst),
    .i_clear (clear),
    .i_freq  (freq),
    .i_step  (nco_step),
    .o_cos   (nco_cos),
    .o_sin   (nco_sin)
  );

  duc_mixer duc_mixer_i (
    .ce_clk      (ce_clk),
    .i_rst       (i_rst),
    .i_clear     (clear),
    .i_scale     (scale),
    .i_in_valid  (interp_valid),
    .o_in_ready  (mix_ready),
    .i_in_data   (interp_data),
    .i_in_last   (interp_last),
    .i_cos       (nco_cos),
    .i_sin       (nco_sin),
    .o_step      (nco_step),
    .o_out_valid (o_out_valid),
    .i_out_ready (i_out_ready),
    .o_out_data  (o_out_data),
    .o_out_last  (o_out_last)
  );

endmodule

`default_nettype wire

//--- hdl/duc_mixer.sv
// Complex mixer with scale and saturation, two pipeline stages that stall together
`timescale 1ns/10ps
`default_nettype none

module duc_mixer (
  input  logic                                ce_clk,
  input  logic                                i_rst,
  input  logic                                i_clear,
  input  logic [duc_pkg::SCALE_W-1:0]         i_scale,

  // Interpolated input stream
  input  logic                                i_in_valid,
  output logic                                o_in_ready,
  input  logic [duc_pkg::ITEM_W-1:0]          i_in_data,
  input  logic                                i_in_last,

  // NCO values and phase step
  input  logic signed [duc_pkg::SAMPLE_W-1:0] i_cos,
  input  logic signed [duc_pkg::SAMPLE_W-1:0] i_sin,
  output logic                                o_step,

  // Output stream
  output logic                                o_out_valid,
  input  logic                                i_out_ready,
  output logic [duc_pkg::ITEM_W-1:0]          o_out_data,
  output logic                                o_out_last
);

  import duc_pkg::*;

  logic                               adv;
  logic                               acc;
  logic signed [SAMPLE_W-1:0]         x_i;
  logic signed [SAMPLE_W-1:0]         x_q;
  logic                               s1_valid;
  logic                               s1_last;
  logic signed [2*SAMPLE_W-1:0]       s1_p_ic;
  logic signed [2*SAMPLE_W-1:0]       s1_p_qs;
  logic signed [2*SAMPLE_W-1:0]       s1_p_is;
  logic signed [2*SAMPLE_W-1:0]       s1_p_qc;
  logic signed [2*SAMPLE_W:0]         sum_i;
  logic signed [2*SAMPLE_W:0]         sum_q;
  logic signed [SAMPLE_W+1:0]         sh_i;
  logic signed [SAMPLE_W+1:0]         sh_q;
  logic signed [SCALE_W:0]            scale_s;
  logic signed [SAMPLE_W+SCALE_W+2:0] scl_i;
  logic signed [SAMPLE_W+SCALE_W+2:0] scl_q;

  // Drop the Q1.14 fraction and clip to the sample range
  function automatic logic [SAMPLE_W-1:0] saturate(
    input logic signed [SAMPLE_W+SCALE_W+2:0] v
  );
    logic signed [SAMPLE_W+SCALE_W+2:0] s;
    s = v >>> 14;
    if (s > 35'sd32767) begin
      saturate = 16'h7FFF;
    end else if (s < -35'sd32768) begin
      saturate = 16'h8000;
    end else begin
      saturate = s[SAMPLE_W-1:0];
    end
  endfunction

  // Whole pipe moves when the output slot is free or draining
  assign adv        = ~o_out_valid | i_out_ready;
  assign acc        = adv & i_in_valid;
  assign o_in_ready = adv;
  assign o_step     = acc;

  assign x_i = i_in_data[SAMPLE_W-1:0];
  assign x_q = i_in_data[ITEM_W-1:SAMPLE_W];

  // ----------------------------------------
  // Stage 1, partial products
  // ----------------------------------------

  always_ff @(posedge ce_clk) begin
    if (acc) begin
      s1_p_ic <= x_i * i_cos;
      s1_p_qs <= x_q * i_sin;
      s1_p_is <= x_i * i_sin;
      s1_p_qc <= x_q * i_cos;
      s1_last <= i_in_last;
    end
  end

  // ----------------------------------------
  // Stage 2, combine, scale, saturate
  // ----------------------------------------

  always_comb begin
    sum_i   = s1_p_ic - s1_p_qs;
    sum_q   = s1_p_is + s1_p_qc;
    // Arithmetic shift by 15 taken as a slice
    sh_i    = sum_i[2*SAMPLE_W:15];
    sh_q    = sum_q[2*SAMPLE_W:15];
    scale_s = {1'b0, i_scale};
    scl_i   = sh_i * scale_s;
    scl_q   = sh_q * scale_s;
  end

  always_ff @(posedge ce_clk) begin
    if (adv && s1_valid) begin
      o_out_data <= {saturate(scl_q), saturate(scl_i)};
      o_out_last <= s1_last;
    end
  end

  // Valid bits, clear flushes older items but keeps this cycle's accept
  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      s1_valid    <= 1'b0;
      o_out_valid <= 1'b0;
    end else begin
      if (adv) begin
        s1_valid <= i_in_valid;
      end else if (i_clear) begin
        s1_valid <= 1'b0;
      end
      if (i_clear) begin
        o_out_valid <= 1'b0;
      end else if (adv) begin
        o_out_valid <= s1_valid;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/duc_nco.sv
// Phase accumulator with sine and cosine lookup, stepped once per sample taken by the mixer
`timescale 1ns/10ps
`default_nettype none

module duc_nco (
  input  logic                                ce_clk,
  input  logic                                i_rst,
  input  logic                                i_clear,
  input  logic [duc_pkg::PHASE_W-1:0]         i_freq,
  input  logic                                i_step,
  output logic signed [duc_pkg::SAMPLE_W-1:0] o_cos,
  output logic signed [duc_pkg::SAMPLE_W-1:0] o_sin
);

  import duc_pkg::*;

  `include "duc_sine_table.svh"

  logic [PHASE_W-1:0]     phase;
  logic [TABLE_ABITS-1:0] sin_idx;
  logic [TABLE_ABITS-1:0] cos_idx;

  // ----------------------------------------
  // Phase accumulator
  // ----------------------------------------

  // Wraps modulo 2^PHASE_W, clear wins over a step in the same cycle
  always_ff @(posedge ce_clk) begin
    if (i_rst || i_clear) begin
      phase <= '0;
    end else if (i_step) begin
      phase <= phase + i_freq;
    end
  end

  // ----------------------------------------
  // Table lookup
  // ----------------------------------------

  // Truncated phase, no dither
  assign sin_idx = phase[PHASE_W-1 -: TABLE_ABITS];

  // Cosine is a quarter turn ahead, address wraps in TABLE_ABITS bits
  assign cos_idx = sin_idx + TABLE_ABITS'(2 ** (TABLE_ABITS - 2));

  assign o_sin = SINE_TABLE[sin_idx];
  assign o_cos = SINE_TABLE[cos_idx];

endmodule

`default_nettype wire

//--- hdl/duc_interp.sv
// Sample-and-hold interpolator, repeats each input item R times toward the mixer
`timescale 1ns/10ps
`default_nettype none

module duc_interp (
  input  logic                       ce_clk,
  input  logic                       i_rst,
  input  logic                       i_clear,
  input  logic [4:0]                 i_interp,

  // Input stream
  input  logic                       i_in_valid,
  output logic                       o_in_ready,
  input  logic [duc_pkg::ITEM_W-1:0] i_in_data,
  input  logic                       i_in_last,

  // Output stream to the mixer
  output logic                       o_out_valid,
  input  logic                       i_out_ready,
  output logic [duc_pkg::ITEM_W-1:0] o_out_data,
  output logic                       o_out_last
);

  import duc_pkg::*;

  interp_state_e     state;
  interp_state_e     state_next;
  logic [ITEM_W-1:0] hold_data;
  logic              hold_last;
  logic [3:0]        rem_cnt;
  logic              final_rep;
  logic              in_xfer;
  logic              out_xfer;

  // ----------------------------------------
  // Handshakes
  // ----------------------------------------

  // rem_cnt counts repeats still to go after the current one
  assign final_rep   = (rem_cnt == 4'd0);
  assign o_out_valid = (state == S_HOLD);
  assign out_xfer    = o_out_valid & i_out_ready;

  // Accept the next item on the same edge the final repeat leaves
  assign o_in_ready  = (state == S_IDLE) | (out_xfer & final_rep);
  assign in_xfer     = i_in_valid & o_in_ready;

  assign o_out_data  = hold_data;

  // Framing only on the last copy of a marked item
  assign o_out_last  = hold_last & final_rep;

  // ----------------------------------------
  // State machine
  // ----------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      S_IDLE: begin
        if (in_xfer) begin
          state_next = S_HOLD;
        end
      end
      S_HOLD: begin
        if (out_xfer && final_rep && !in_xfer) begin
          state_next = S_IDLE;
        end
      end
      default: begin
        state_next = S_IDLE;
      end
    endcase
    // A transfer in the clear cycle is kept, anything older is dropped
    if (i_clear && !in_xfer) begin
      state_next = S_IDLE;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      state <= S_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Hold register and repeat count, R latched with the item
  always_ff @(posedge ce_clk) begin
    if (in_xfer) begin
      hold_data <= i_in_data;
      hold_last <= i_in_last;
      rem_cnt   <= 4'(i_interp - 5'd1);
    end else if (out_xfer) begin
      rem_cnt   <= rem_cnt - 4'd1;
    end
  end

endmodule

`default_nettype wire

//--- hdl/duc_settings.sv
// Settings-bus register file of the up-converter, instanced once in duc_top
`timescale 1ns/10ps
`default_nettype none

module duc_settings (
  input  logic                        ce_clk,
  input  logic                        i_rst,

  // Write side
  input  logic                        i_set_stb,
  input  logic [7:0]                  i_set_addr,
  input  logic [31:0]                 i_set_data,

  // Readback side
  input  logic [7:0]                  i_rb_addr,
  output logic [31:0]                 o_rb_data,

  // Register outputs to the chain
  output logic [duc_pkg::PHASE_W-1:0] o_freq,
  output logic [duc_pkg::SCALE_W-1:0] o_scale,
  output logic [4:0]                  o_interp,
  output logic                        o_clear
);

  import duc_pkg::*;

  logic [4:0] interp_clip;

  // Factor is stored already limited to 1..INTERP_MAX
  always_comb begin
    if (i_set_data == 32'd0) begin
      interp_clip = 5'd1;
    end else if (i_set_data > 32'(INTERP_MAX)) begin
      interp_clip = 5'(INTERP_MAX);
    end else begin
      interp_clip = i_set_data[4:0];
    end
  end

  // ----------------------------------------
  // Write decode
  // ----------------------------------------

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      o_freq   <= '0;
      o_scale  <= SCALE_RESET;
      o_interp <= INTERP_RESET;
      o_clear  <= 1'b0;
    end else begin
      // Clear is a strobe, only one cycle wide
      o_clear <= 1'b0;
      if (i_set_stb) begin
        case (reg_addr_e'(i_set_addr))
          SR_FREQ:   o_freq   <= i_set_data[PHASE_W-1:0];
          SR_SCALE:  o_scale  <= i_set_data[SCALE_W-1:0];
          SR_INTERP: o_interp <= interp_clip;
          SR_CLEAR:  o_clear  <= 1'b1;
          default:   ;
        endcase
      end
    end
  end

  // ----------------------------------------
  // Readback mux
  // ----------------------------------------

  // Registered, so data follows the address by one clock
  always_ff @(posedge ce_clk) begin
    case (reg_addr_e'(i_rb_addr))
      RB_COMPAT:     o_rb_data <= COMPAT_NUM;
      RB_INTERP_MAX: o_rb_data <= 32'(INTERP_MAX);
      RB_FREQ:       o_rb_data <= 32'(o_freq);
      default:       o_rb_data <= RB_DEFAULT;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/duc_pkg.sv
// Shared widths, settings addresses and reset values of the up-converter chain, compile first

package duc_pkg;

  // ----------------------------------------
  // Data path widths
  // ----------------------------------------

  // One I or Q component, Q sits in the upper half of an item
  localparam int SAMPLE_W    = 16;
  localparam int ITEM_W      = 2 * SAMPLE_W;

  // NCO phase and table address (top bits of the phase)
  localparam int PHASE_W     = 16;
  localparam int TABLE_ABITS = 6;

  // Unsigned Q1.14 gain
  localparam int SCALE_W     = 16;

  // Largest repeat count of the interpolator
  localparam int INTERP_MAX  = 16;

  // ----------------------------------------
  // Settings bus map
  // ----------------------------------------

  // Writes and readback share one 8-bit space
  typedef enum logic [7:0] {
    RB_COMPAT     = 8'h00,
    RB_INTERP_MAX = 8'h01,
    RB_FREQ       = 8'h02,
    SR_FREQ       = 8'h10,
    SR_SCALE      = 8'h11,
    SR_INTERP     = 8'h12,
    SR_CLEAR      = 8'h13
  } reg_addr_e;

  localparam logic [31:0]        COMPAT_NUM   = 32'h0000_0001;
  localparam logic [31:0]        RB_DEFAULT   = 32'h0BAD_C0DE;

  // Unity gain and no rate change out of reset
  localparam logic [SCALE_W-1:0] SCALE_RESET  = 16'd16384;
  localparam logic [4:0]         INTERP_RESET = 5'd1;

  // Interpolator hold states
  typedef enum logic {
    S_IDLE,
    S_HOLD
  } interp_state_e;

endpackage

//--- include/duc_sine_table.svh
// Sine lookup for the NCO and the reference model, include inside a module body after the package import

// ----------------------------------------
// One full turn in 64 steps, amplitude 32767
// ----------------------------------------
// Cosine is read a quarter turn ahead (index + 16)
localparam logic signed [15:0] SINE_TABLE [64] = '{
  16'sd0,      16'sd3212,   16'sd6393,   16'sd9512,
  16'sd12539,  16'sd15446,  16'sd18204,  16'sd20787,
  16'sd23170,  16'sd25329,  16'sd27245,  16'sd28898,
  16'sd30273,  16'sd31356,  16'sd32137,  16'sd32609,
  16'sd32767,  16'sd32609,  16'sd32137,  16'sd31356,
  16'sd30273,  16'sd28898,  16'sd27245,  16'sd25329,
  16'sd23170,  16'sd20787,  16'sd18204,  16'sd15446,
  16'sd12539,  16'sd9512,   16'sd6393,   16'sd3212,
  16'sd0,      -16'sd3212,  -16'sd6393,  -16'sd9512,
  -16'sd12539, -16'sd15446, -16'sd18204, -16'sd20787,
  -16'sd23170, -16'sd25329, -16'sd27245, -16'sd28898,
  -16'sd30273, -16'sd31356, -16'sd32137, -16'sd32609,
  -16'sd32767, -16'sd32609, -16'sd32137, -16'sd31356,
  -16'sd30273, -16'sd28898, -16'sd27245, -16'sd25329,
  -16'sd23170, -16'sd20787, -16'sd18204, -16'sd15446,
  -16'sd12539, -16'sd9512,  -16'sd6393,  -16'sd3212
};
